/* coreCfgPkg.sv */
`default_nettype none

package coreCfgPkg;

    localparam int XLEN = 32;
    localparam int NUM_ARCH_REGS = 16; // x0 reads zero
    localparam int ROB_SIZE = 16;
    localparam int IQ_SIZE = 4;

    typedef logic [XLEN-1:0] Word;
    typedef logic [3:0] ArchReg;
    typedef logic [3:0] Tag; // ROB index doubles as result tag
    typedef logic [4:0] SqN; // extra wrap bit for age compares

    typedef enum logic {
        LONG_DIV,
        LONG_MUL
    } LongFu;

endpackage

`default_nettype wire

/* uopPkg.sv */
`default_nettype none

package uopPkg;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_XOR,
        OP_SLTU,
        OP_MUL,
        OP_DIVU
    } OpCode;

    typedef struct packed {
        logic valid;
        OpCode op;
        coreCfgPkg::ArchReg dst;
        coreCfgPkg::ArchReg srcA;
        coreCfgPkg::ArchReg srcB;
        logic useImm; // imm replaces srcB
        coreCfgPkg::Word imm;
    } DispatchUOp;

    typedef struct packed {
        logic ready;
        coreCfgPkg::Tag tag; // producer when not ready
        coreCfgPkg::Word value;
    } Operand;

    typedef struct packed {
        logic valid;
        OpCode op;
        coreCfgPkg::SqN sqN; // low bits are the result tag
        Operand srcA;
        Operand srcB;
    } IssueUOp;

    typedef struct packed {
        logic valid;
        coreCfgPkg::Tag tag;
        coreCfgPkg::Word value;
    } ResultUOp;

    typedef struct packed {
        logic valid;
        coreCfgPkg::SqN sqN;
        coreCfgPkg::ArchReg dst;
        coreCfgPkg::Word value;
    } CommitUOp;

endpackage

`default_nettype wire

/* Divide.sv */
`default_nettype none

module Divide (
    input wire clk,
    input wire reset,
    input wire start,
    input wire coreCfgPkg::Tag tag,
    input wire coreCfgPkg::Word dividend,
    input wire coreCfgPkg::Word divisor,
    output logic busy,
    output logic finishNext,
    output uopPkg::ResultUOp result
);
    import coreCfgPkg::*;
    import uopPkg::*;

    Word rem;
    Word quo; // dividend shifts out as quotient bits shift in
    Word div;
    Tag curTag;
    logic [4:0] cnt;
    logic [63:0] nextStep;

    // restoring step that turns a zero divisor into an all-ones quotient
    function automatic logic [63:0] step(Word r, Word q, Word d);
        logic [32:0] trial;
        trial = {r, q[31]};
        if (trial >= {1'b0, d}) begin
            trial = trial - {1'b0, d};
            return {trial[31:0], q[30:0], 1'b1};
        end
        return {trial[31:0], q[30:0], 1'b0};
    endfunction

    assign nextStep = busy ? step(rem, quo, div) : step('0, dividend, divisor);
    assign finishNext = busy && cnt == 5'd1;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            result.valid <= 1'b0;
        end else begin
            result.valid <= finishNext;
            if (start) begin // first step happens on load
                busy <= 1'b1;
                cnt <= 5'd31;
                div <= divisor;
                curTag <= tag;
            end else if (busy) begin
                cnt <= cnt - 5'd1;
                if (finishNext) busy <= 1'b0;
            end
        end
        {rem, quo} <= nextStep;
        result.tag <= curTag;
        result.value <= nextStep[31:0];
    end

endmodule

`default_nettype wire

/* Multiply.sv */
`default_nettype none

module Multiply (
    input wire clk,
    input wire reset,
    input wire start,
    input wire coreCfgPkg::Tag tag,
    input wire coreCfgPkg::Word a,
    input wire coreCfgPkg::Word b,
    output logic finishNext,
    output uopPkg::ResultUOp result
);
    import coreCfgPkg::*;
    import uopPkg::*;

    logic s1Valid;
    logic s2Valid;
    Tag s1Tag;
    Tag s2Tag;
    Word s1A;
    Word s1B;
    Word s2Prod; // low half only

    always_ff @(posedge clk) begin
        if (reset) begin
            s1Valid <= 1'b0;
            s2Valid <= 1'b0;
            result.valid <= 1'b0;
        end else begin
            s1Valid <= start;
            s2Valid <= s1Valid;
            result.valid <= s2Valid;
        end
        s1Tag <= tag;
        s1A <= a;
        s1B <= b;
        s2Tag <= s1Tag;
        s2Prod <= s1A * s1B;
        result.tag <= s2Tag;
        result.value <= s2Prod;
    end

    assign finishNext = s2Valid;

endmodule

`default_nettype wire

/* ExecLane.sv */
`default_nettype none

module ExecLane #(
    parameter coreCfgPkg::LongFu LONG_KIND = coreCfgPkg::LONG_DIV
) (
    input wire clk,
    input wire reset,
    input wire uopPkg::IssueUOp issue,
    output uopPkg::ResultUOp result,
    output logic blockInt,
    output logic blockLong
);
    import coreCfgPkg::*;
    import uopPkg::*;

    ResultUOp aluRes;
    ResultUOp longRes;
    logic longFinishNext;
    logic isLong;

    function automatic Word aluCompute(OpCode op, Word a, Word b);
        case (op)
            OP_ADD: return a + b;
            OP_SUB: return a - b;
            OP_AND: return a & b;
            OP_XOR: return a ^ b;
            default: return {31'b0, a < b}; // sltu
        endcase
    endfunction

    assign isLong = issue.op == OP_MUL || issue.op == OP_DIVU;

    always_ff @(posedge clk) begin
        if (reset) aluRes.valid <= 1'b0;
        else aluRes.valid <= issue.valid && !isLong;
        aluRes.tag <= issue.sqN[3:0];
        aluRes.value <= aluCompute(issue.op, issue.srcA.value, issue.srcB.value);
    end

    if (LONG_KIND == LONG_DIV) begin : gDiv
        logic divBusy;
        logic divPending; // latched DIVU waiting one cycle to start
        Tag divTag;
        Word divA;
        Word divB;

        always_ff @(posedge clk) begin
            if (reset) divPending <= 1'b0;
            else divPending <= issue.valid && isLong;
            divTag <= issue.sqN[3:0];
            divA <= issue.srcA.value;
            divB <= issue.srcB.value;
        end

        Divide div (
            .clk(clk),
            .reset(reset),
            .start(divPending),
            .tag(divTag),
            .dividend(divA),
            .divisor(divB),
            .busy(divBusy),
            .finishNext(longFinishNext),
            .result(longRes)
        );
        assign blockLong = divBusy || divPending;
    end else begin : gMul
        Multiply mul (
            .clk(clk),
            .reset(reset),
            .start(issue.valid && isLong),
            .tag(issue.sqN[3:0]),
            .a(issue.srcA.value),
            .b(issue.srcB.value),
            .finishNext(longFinishNext),
            .result(longRes)
        );
        assign blockLong = 1'b0; // fully pipelined
    end

    assign blockInt = longFinishNext;
    assign result = longRes.valid ? longRes : aluRes;

    // blockInt has to keep the ALU off the long unit's writeback slot
    assert property (@(posedge clk) disable iff (reset) !(aluRes.valid && longRes.valid));

endmodule

`default_nettype wire

/* IssueQueue.sv */
`default_nettype none

module IssueQueue #(
    parameter int DEPTH = 4
) (
    input wire clk,
    input wire reset,
    input wire uopPkg::IssueUOp enq,
    output logic free,
    input wire uopPkg::ResultUOp result0,
    input wire uopPkg::ResultUOp result1,
    input wire blockInt,
    input wire blockLong,
    output uopPkg::IssueUOp issue
);
    import coreCfgPkg::*;
    import uopPkg::*;

    IssueUOp entries[DEPTH];
    logic selValid;
    int selIdx;
    int freeIdx;

    function automatic logic older(SqN a, SqN b);
        SqN diff;
        diff = a - b;
        return diff[4];
    endfunction

    function automatic Operand wake(Operand o, ResultUOp r0, ResultUOp r1);
        Operand n;
        n = o;
        if (!o.ready && r0.valid && r0.tag == o.tag) begin
            n.ready = 1'b1;
            n.value = r0.value;
        end else if (!o.ready && r1.valid && r1.tag == o.tag) begin
            n.ready = 1'b1;
            n.value = r1.value;
        end
        return n;
    endfunction

    function automatic logic eligible(IssueUOp e, logic bInt, logic bLong);
        logic isLong;
        isLong = e.op == OP_MUL || e.op == OP_DIVU;
        return e.valid && e.srcA.ready && e.srcB.ready && !(isLong ? bLong : bInt);
    endfunction

    always_comb begin
        selValid = 1'b0;
        selIdx = 0;
        freeIdx = 0;
        free = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            if (eligible(entries[i], blockInt, blockLong) &&
                (!selValid || older(entries[i].sqN, entries[selIdx].sqN))) begin
                selValid = 1'b1;
                selIdx = i;
            end
            if (!entries[i].valid && !free) begin
                free = 1'b1;
                freeIdx = i;
            end
        end
        issue = entries[selIdx];
        issue.valid = selValid;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) entries[i].valid <= 1'b0;
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                entries[i].srcA <= wake(entries[i].srcA, result0, result1);
                entries[i].srcB <= wake(entries[i].srcB, result0, result1);
                if (selValid && selIdx == i) entries[i].valid <= 1'b0;
            end
            if (enq.valid) entries[freeIdx] <= enq;
        end
    end

    // dispatch only routes here while a slot is open
    assert property (@(posedge clk) disable iff (reset) enq.valid |-> free);

endmodule

`default_nettype wire

/* RenameDispatch.sv */
`default_nettype none

module RenameDispatch (
    input wire clk,
    input wire reset,
    input wire uopPkg::DispatchUOp dispatch,
    output logic ready,
    input wire coreCfgPkg::Tag robTail,
    input wire robFull,
    output logic robAlloc,
    output coreCfgPkg::Tag robReadTag,
    input wire robReadDone,
    input wire coreCfgPkg::Word robReadValue,
    input wire [1:0] iqFree,
    input wire uopPkg::ResultUOp result0,
    input wire uopPkg::ResultUOp result1,
    input wire uopPkg::CommitUOp commit,
    output uopPkg::IssueUOp iqIn0,
    output uopPkg::IssueUOp iqIn1
);
    import coreCfgPkg::*;
    import uopPkg::*;

    Word regFile[NUM_ARCH_REGS];
    logic mapBusy[NUM_ARCH_REGS];
    logic mapDone[NUM_ARCH_REGS]; // result seen on a bus, not yet retired
    Tag mapTag[NUM_ARCH_REGS];
    Word mapValue[NUM_ARCH_REGS];
    logic wrap;
    logic accept;
    logic toQ0;
    SqN sqN;
    Operand opA;
    Operand opB;
    IssueUOp uop;

    assign ready = !robFull && iqFree[0] && iqFree[1];
    assign accept = dispatch.valid && ready;
    assign robAlloc = accept;
    assign robReadTag = mapTag[dispatch.srcA];
    assign sqN = {wrap, robTail};

    always_comb begin
        opA.tag = mapTag[dispatch.srcA];
        opA.ready = 1'b1;
        if (!mapBusy[dispatch.srcA]) opA.value = regFile[dispatch.srcA];
        else if (robReadDone) opA.value = robReadValue;
        else if (result0.valid && result0.tag == opA.tag) opA.value = result0.value;
        else if (result1.valid && result1.tag == opA.tag) opA.value = result1.value;
        else begin
            opA.ready = 1'b0;
            opA.value = '0;
        end

        // srcB has no ROB port so the map keeps the value caught off the buses
        opB.tag = mapTag[dispatch.srcB];
        opB.ready = 1'b1;
        if (dispatch.useImm) opB.value = dispatch.imm;
        else if (!mapBusy[dispatch.srcB]) opB.value = regFile[dispatch.srcB];
        else if (mapDone[dispatch.srcB]) opB.value = mapValue[dispatch.srcB];
        else if (result0.valid && result0.tag == opB.tag) opB.value = result0.value;
        else if (result1.valid && result1.tag == opB.tag) opB.value = result1.value;
        else begin
            opB.ready = 1'b0;
            opB.value = '0;
        end
    end

    // long ops are pinned while ALU ops alternate by age
    assign toQ0 = dispatch.op == OP_DIVU || (dispatch.op != OP_MUL && !sqN[0]);

    always_comb begin
        uop = '{valid: accept, op: dispatch.op, sqN: sqN, srcA: opA, srcB: opB};
        iqIn0 = uop;
        iqIn1 = uop;
        iqIn0.valid = accept && toQ0;
        iqIn1.valid = accept && !toQ0;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wrap <= 1'b0;
            for (int r = 0; r < NUM_ARCH_REGS; r++) begin
                regFile[r] <= '0;
                mapBusy[r] <= 1'b0;
                mapDone[r] <= 1'b0;
            end
        end else begin
            if (accept && &robTail) wrap <= ~wrap;
            for (int r = 0; r < NUM_ARCH_REGS; r++) begin
                if (mapBusy[r] && result0.valid && result0.tag == mapTag[r]) begin
                    mapDone[r] <= 1'b1;
                    mapValue[r] <= result0.value;
                end
                if (mapBusy[r] && result1.valid && result1.tag == mapTag[r]) begin
                    mapDone[r] <= 1'b1;
                    mapValue[r] <= result1.value;
                end
            end
            if (commit.valid && commit.dst != '0) begin
                regFile[commit.dst] <= commit.value;
                if (mapTag[commit.dst] == commit.sqN[3:0]) mapBusy[commit.dst] <= 1'b0;
            end
            if (accept && dispatch.dst != '0) begin // a newer rename wins over commit
                mapBusy[dispatch.dst] <= 1'b1;
                mapDone[dispatch.dst] <= 1'b0;
                mapTag[dispatch.dst] <= robTail;
            end
        end
    end

    // a full ROB takes no new entry, so its tail holds until a slot drains
    assert property (@(posedge clk) disable iff (reset)
        robFull |=> robTail == $past(robTail));

endmodule

`default_nettype wire

/* ReorderBuffer.sv */
`default_nettype none

module ReorderBuffer #(
    parameter int DEPTH = 16
) (
    input wire clk,
    input wire reset,
    input wire alloc,
    input wire coreCfgPkg::ArchReg allocDst,
    output coreCfgPkg::Tag tail,
    output logic full,
    input wire coreCfgPkg::Tag readTag,
    output logic readDone,
    output coreCfgPkg::Word readValue,
    input wire uopPkg::ResultUOp result0,
    input wire uopPkg::ResultUOp result1,
    output uopPkg::CommitUOp commit
);
    import coreCfgPkg::*;
    import uopPkg::*;

    logic done[DEPTH];
    ArchReg dst[DEPTH];
    Word value[DEPTH];
    SqN head;
    SqN tailSqN;
    SqN count;

    function automatic logic inFlight(Tag t, SqN h, SqN c);
        Tag off;
        off = t - h[3:0];
        return {1'b0, off} < c;
    endfunction

    assign count = tailSqN - head;
    assign full = count == SqN'(DEPTH);
    assign tail = tailSqN[3:0];
    assign readDone = done[readTag];
    assign readValue = value[readTag];

    always_comb begin
        commit.valid = count != '0 && done[head[3:0]];
        commit.sqN = head;
        commit.dst = dst[head[3:0]];
        commit.value = value[head[3:0]];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            head <= '0;
            tailSqN <= '0;
            for (int i = 0; i < DEPTH; i++) done[i] <= 1'b0;
        end else begin
            if (result0.valid) begin
                done[result0.tag] <= 1'b1;
                value[result0.tag] <= result0.value;
            end
            if (result1.valid) begin
                done[result1.tag] <= 1'b1;
                value[result1.tag] <= result1.value;
            end
            if (alloc) begin
                done[tail] <= 1'b0;
                dst[tail] <= allocDst;
                tailSqN <= tailSqN + SqN'(1);
            end
            if (commit.valid) head <= head + SqN'(1); // one retire per cycle
        end
    end

    // a lane must only write back into a live entry
    assert property (@(posedge clk) disable iff (reset)
        result0.valid |-> inFlight(result0.tag, head, count));
    assert property (@(posedge clk) disable iff (reset)
        result1.valid |-> inFlight(result1.tag, head, count));

endmodule

`default_nettype wire

/* Core.sv */
`default_nettype none

module Core #(
    parameter int ROB_DEPTH = coreCfgPkg::ROB_SIZE,
    parameter int IQ_DEPTH = coreCfgPkg::IQ_SIZE
) (
    input wire clk,
    input wire reset,
    input wire uopPkg::DispatchUOp dispatch,
    output logic ready,
    output uopPkg::CommitUOp commit
);
    import coreCfgPkg::*;
    import uopPkg::*;

    Tag robTail;
    logic robFull;
    logic robAlloc;
    Tag robReadTag;
    logic robReadDone;
    Word robReadValue;
    logic [1:0] iqFree;
    IssueUOp iqIn[2];
    IssueUOp issue[2];
    ResultUOp result[2];
    logic blockInt[2];
    logic blockLong[2];

    RenameDispatch rename (
        .clk(clk),
        .reset(reset),
        .dispatch(dispatch),
        .ready(ready),
        .robTail(robTail),
        .robFull(robFull),
        .robAlloc(robAlloc),
        .robReadTag(robReadTag),
        .robReadDone(robReadDone),
        .robReadValue(robReadValue),
        .iqFree(iqFree),
        .result0(result[0]),
        .result1(result[1]),
        .commit(commit),
        .iqIn0(iqIn[0]),
        .iqIn1(iqIn[1])
    );

    // lane 0 hosts the divider, lane 1 the multiplier
    for (genvar i = 0; i < 2; i++) begin : gLane
        IssueQueue #(.DEPTH(IQ_DEPTH)) iq (
            .clk(clk),
            .reset(reset),
            .enq(iqIn[i]),
            .free(iqFree[i]),
            .result0(result[0]),
            .result1(result[1]),
            .blockInt(blockInt[i]),
            .blockLong(blockLong[i]),
            .issue(issue[i])
        );

        ExecLane #(.LONG_KIND(i == 0 ? LONG_DIV : LONG_MUL)) lane (
            .clk(clk),
            .reset(reset),
            .issue(issue[i]),
            .result(result[i]),
            .blockInt(blockInt[i]),
            .blockLong(blockLong[i])
        );
    end

    ReorderBuffer #(.DEPTH(ROB_DEPTH)) rob (
        .clk(clk),
        .reset(reset),
        .alloc(robAlloc),
        .allocDst(dispatch.dst),
        .tail(robTail),
        .full(robFull),
        .readTag(robReadTag),
        .readDone(robReadDone),
        .readValue(robReadValue),
        .result0(result[0]),
        .result1(result[1]),
        .commit(commit)
    );

endmodule

`default_nettype wire

/* tbCore.sv */
`default_nettype none

module tbCore;
    import coreCfgPkg::*;
    import uopPkg::*;

    localparam int N_INDEP = 24;
    localparam int N_CHAIN = 15;
    localparam int N_BURST = 32;
    localparam int N_RANDOM = 400;
    localparam int TIMEOUT_CYCLES = 60 * (N_INDEP + N_CHAIN + N_BURST + N_RANDOM) + 100;

    logic clk;
    logic reset;
    DispatchUOp dispatch;
    logic ready;
    CommitUOp commit;

    Word archRegs[NUM_ARCH_REGS]; // in dispatch order
    CommitUOp expQ[$];
    SqN nextSqN;
    int inFlight;
    int cycleCount;
    logic sawFull;
    logic [31:0] rngState;

    Core #(.ROB_DEPTH(ROB_SIZE), .IQ_DEPTH(IQ_SIZE)) Core_inst (
        .clk(clk),
        .reset(reset),
        .dispatch(dispatch),
        .ready(ready),
        .commit(commit)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] nextRand();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    function automatic Word refResult(OpCode op, Word a, Word b);
        case (op)
            OP_ADD: return a + b;
            OP_SUB: return a - b;
            OP_AND: return a & b;
            OP_XOR: return a ^ b;
            OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
            OP_MUL: return a * b; // low half
            OP_DIVU: return (b == '0) ? '1 : a / b;
            default: return '0;
        endcase
    endfunction

    task automatic abortRun(string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic checkReady(logic exp);
        if (ready !== exp)
            abortRun($sformatf("** Error at %0t: ready expected %b, got %b", $time, exp, ready));
    endtask

    task automatic checkCommit(CommitUOp exp, CommitUOp act);
        if (act.sqN !== exp.sqN)
            abortRun($sformatf("** Error at %0t: commit.sqN expected %h, got %h",
                $time, exp.sqN, act.sqN));
        if (act.dst !== exp.dst)
            abortRun($sformatf("** Error at %0t: commit.dst expected %h, got %h",
                $time, exp.dst, act.dst));
        if (act.value !== exp.value)
            abortRun($sformatf("** Error at %0t: commit.value expected %h, got %h",
                $time, exp.value, act.value));
    endtask

    task automatic idle(int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // holds the uop until ready, then updates the model as the DUT accepts it
    task automatic sendUop(OpCode op, ArchReg dst, ArchReg srcA, ArchReg srcB,
                           logic useImm, Word imm);
        Word a;
        Word b;
        Word val;
        CommitUOp exp;
        dispatch = '{valid: 1'b1, op: op, dst: dst, srcA: srcA, srcB: srcB,
                     useImm: useImm, imm: imm};
        while (!ready) begin
            @(posedge clk);
            #1;
        end
        a = archRegs[srcA];
        b = useImm ? imm : archRegs[srcB];
        val = refResult(op, a, b);
        if (dst != '0) archRegs[dst] = val; // x0 stays zero
        exp = '{valid: 1'b1, sqN: nextSqN, dst: dst, value: val};
        expQ.push_back(exp);
        nextSqN = nextSqN + SqN'(1);
        @(posedge clk);
        #1;
        inFlight++;
        dispatch.valid = 1'b0;
    endtask

    // commit and ready only move on the rising edge
    always @(negedge clk) begin : compareCommits
        CommitUOp exp;
        if (!reset) begin
            if (inFlight > ROB_SIZE) abortRun("more uops accepted than the ROB can hold");
            if (inFlight == ROB_SIZE) begin
                sawFull = 1'b1;
                checkReady(1'b0);
            end
            if (commit.valid) begin
                if (expQ.size() == 0) begin
                    abortRun("a commit arrived with no uop outstanding");
                end else begin
                    exp = expQ.pop_front();
                    checkCommit(exp, commit);
                    inFlight--;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > TIMEOUT_CYCLES) abortRun("timeout waiting for commits to drain");
    end

    initial begin
        logic [31:0] r;
        rngState = 32'd20;
        nextSqN = '0;
        inFlight = 0;
        cycleCount = 0;
        sawFull = 1'b0;
        for (int i = 0; i < NUM_ARCH_REGS; i++) archRegs[i] = '0;
        reset = 1'b1;
        dispatch = '0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        idle(1);
        checkReady(1'b1);
        if (commit.valid !== 1'b0) abortRun("commit is valid right after reset");

        // independent loads, then ALU ops over them
        for (int i = 1; i < NUM_ARCH_REGS; i++)
            sendUop(OP_ADD, ArchReg'(i), '0, '0, 1'b1, nextRand());
        for (int i = 0; i < 9; i++)
            sendUop(OpCode'(i % 5), ArchReg'(1 + i), ArchReg'(15 - i),
                    ArchReg'(1 + (i * 3) % 15), 1'b0, '0);

        // dependent chain through the long units
        sendUop(OP_ADD, 4'd1, 4'd0, 4'd0, 1'b1, 32'd1000);
        sendUop(OP_ADD, 4'd2, 4'd0, 4'd0, 1'b1, 32'd7);
        sendUop(OP_MUL, 4'd3, 4'd1, 4'd2, 1'b0, '0);
        sendUop(OP_DIVU, 4'd4, 4'd3, 4'd2, 1'b0, '0);
        sendUop(OP_DIVU, 4'd5, 4'd4, 4'd0, 1'b0, '0); // divide by x0
        sendUop(OP_DIVU, 4'd6, 4'd1, 4'd0, 1'b1, 32'd0);
        sendUop(OP_ADD, 4'd0, 4'd1, 4'd0, 1'b1, 32'd5); // write to x0 dropped
        sendUop(OP_ADD, 4'd7, 4'd0, 4'd2, 1'b0, '0);
        sendUop(OP_MUL, 4'd8, 4'd5, 4'd3, 1'b0, '0);
        sendUop(OP_SUB, 4'd9, 4'd8, 4'd4, 1'b0, '0);
        sendUop(OP_SLTU, 4'd10, 4'd9, 4'd3, 1'b0, '0);
        sendUop(OP_XOR, 4'd11, 4'd10, 4'd0, 1'b1, 32'h5a5a_0f0f);
        sendUop(OP_DIVU, 4'd12, 4'd11, 4'd0, 1'b1, 32'd3);
        sendUop(OP_MUL, 4'd0, 4'd12, 4'd12, 1'b0, '0);
        sendUop(OP_AND, 4'd13, 4'd0, 4'd12, 1'b0, '0);

        // a slow divide at the head lets the ROB fill up behind it
        for (int i = 0; i < N_BURST; i++) begin
            if (i % 8 == 0)
                sendUop(OP_DIVU, ArchReg'(8 + i / 8), ArchReg'(3 + i / 8), '0,
                        1'b1, Word'(i % 5));
            else
                sendUop(OP_ADD, ArchReg'(2 + i % 6), 4'd1, '0, 1'b1, Word'(i));
        end
        if (!sawFull) abortRun("the ROB never filled during the divide burst");

        for (int n = 0; n < N_RANDOM; n++) begin
            r = nextRand();
            sendUop(OpCode'(r % 32'd7), r[7:4], r[11:8], r[15:12], r[16],
                    r[17] ? Word'(r[20:18]) : nextRand());
            if (r[31:29] == 3'd0) idle(1);
        end

        while (expQ.size() != 0) @(posedge clk);
        idle(10); // any stray commit shows up here
        if (expQ.size() == 0 && inFlight == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("STATUS: FAIL");
            $fatal(1, "uops still outstanding at the end of the run");
        end
    end

endmodule

`default_nettype wire

/* tb.f */
coreCfgPkg.sv
uopPkg.sv
Divide.sv
Multiply.sv
ExecLane.sv
IssueQueue.sv
RenameDispatch.sv
ReorderBuffer.sv
Core.sv
tbCore.sv

/* Makefile */
TOP = tbCore

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f -o $(TOP)

run: compile
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
